// ==== rtl/conv_pkg.sv ====
package conv_pkg;

	// operand widths
	parameter int NEURON_W = 8;
	parameter int WEIGHT_W = 8;

	// 36 products of 16 bits each fit in 22 bits
	parameter int ACC_W = 22;

	// largest lane count the host map can address
	parameter int MAX_LANES = 4;

	// tap index covers up to 36 taps
	parameter int TAP_W = 6;

	typedef logic [NEURON_W-1:0] neuron_t;
	typedef logic [WEIGHT_W-1:0] weight_t;
	typedef logic [ACC_W-1:0]    acc_t;
	typedef logic [TAP_W-1:0]    tap_t;

	// filter select, one of MAX_LANES
	typedef logic [1:0] lane_sel_t;

endpackage

// ==== rtl/apb_map_pkg.sv ====
package apb_map_pkg;

	parameter int APB_ADDR_W = 8;
	parameter int APB_DATA_W = 32;

	// register offsets
	parameter logic [APB_ADDR_W-1:0] CTRL_ADDR   = 8'h00;
	parameter logic [APB_ADDR_W-1:0] CONFIG_ADDR = 8'h04;
	parameter logic [APB_ADDR_W-1:0] STATUS_ADDR = 8'h08;
	parameter logic [APB_ADDR_W-1:0] WEIGHT_ADDR = 8'h10;
	parameter logic [APB_ADDR_W-1:0] NEURON_ADDR = 8'h14;
	// lane k sits at RESULT_BASE + 4k
	parameter logic [APB_ADDR_W-1:0] RESULT_BASE = 8'h20;

	// field positions
	parameter int CTRL_START_BIT       = 0;
	parameter int CTRL_LAYER_RESET_BIT = 1;
	parameter int CONFIG_SIZE_LSB      = 0;
	parameter int CONFIG_FILTERS_LSB   = 8;
	parameter int STATUS_BUSY_BIT      = 0;
	parameter int STATUS_DONE_BIT      = 1;

endpackage

// ==== rtl/mac_ctrl_if.sv ====
`timescale 1ns/1ps

interface mac_ctrl_if #(
	parameter int NUM_LANES = 4
);

	logic                 tap_valid;
	conv_pkg::tap_t       tap_idx;
	logic                 acc_clear;
	logic                 acc_last;
	// thermometer coded, lane 0 always first
	logic [NUM_LANES-1:0] lane_mask;

	modport seq (
		output tap_valid, tap_idx, acc_clear, acc_last, lane_mask
	);

	modport array (
		input tap_valid, tap_idx, acc_clear, acc_last, lane_mask
	);

endinterface

// ==== rtl/tap_counter.sv ====
`timescale 1ns/1ps

module tap_counter (
	input  logic           clk,
	input  logic           reset,
	input  logic           clear_i,
	input  logic           step_i,
	input  conv_pkg::tap_t limit_i,
	output conv_pkg::tap_t count_o,
	output logic           wrap_o
);

	logic at_limit;

	assign at_limit = (count_o == limit_i);
	assign wrap_o   = step_i & at_limit;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			count_o <= '0;
		end else if (clear_i) begin
			count_o <= '0;
		end else if (step_i) begin
			// limit is stored as value minus one
			if (at_limit) begin
				count_o <= '0;
			end else begin
				count_o <= count_o + 1'b1;
			end
		end
	end

endmodule

// ==== rtl/tap_buffer.sv ====
`timescale 1ns/1ps

module tap_buffer #(
	parameter type payload_t  = conv_pkg::weight_t,
	parameter int  POOL_DEPTH = 36
) (
	input  logic           clk,
	input  logic           we_i,
	input  conv_pkg::tap_t waddr_i,
	input  payload_t       wdata_i,
	input  conv_pkg::tap_t raddr_i,
	output payload_t       rdata_o
);

	payload_t mem [POOL_DEPTH];

	// one write port, registered read
	always_ff @(posedge clk) begin
		if (we_i) begin
			mem[waddr_i] <= wdata_i;
		end
		rdata_o <= mem[raddr_i];
	end

endmodule

// ==== rtl/apb_regs.sv ====
`timescale 1ns/1ps

module apb_regs #(
	parameter int NUM_LANES  = 4,
	parameter int POOL_DEPTH = 36
) (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                psel_i,
	input  logic                                penable_i,
	input  logic                                pwrite_i,
	input  logic [apb_map_pkg::APB_ADDR_W-1:0]  paddr_i,
	input  logic [apb_map_pkg::APB_DATA_W-1:0]  pwdata_i,
	input  logic                                busy_i,
	input  logic                                done_i,
	input  conv_pkg::acc_t                      results_i [NUM_LANES],
	output logic [apb_map_pkg::APB_DATA_W-1:0]  prdata_o,
	output logic                                pready_o,
	output logic                                pslverr_o,
	output conv_pkg::tap_t                      filter_size_o,
	output conv_pkg::lane_sel_t                 num_filters_o,
	output logic                                start_o,
	output logic                                layer_reset_o,
	output logic                                weight_we_o,
	output logic                                neuron_we_o,
	output conv_pkg::weight_t                   wdata_o
);

	logic                               access;
	logic                               ctrl_hit;
	logic                               config_hit;
	logic                               status_hit;
	logic                               weight_hit;
	logic                               neuron_hit;
	logic                               result_hit;
	logic                               writable;
	logic                               readable;
	logic                               wr_ok;
	logic [apb_map_pkg::APB_ADDR_W-1:0] result_off;
	conv_pkg::lane_sel_t                result_lane;
	conv_pkg::tap_t                     size_wr;
	conv_pkg::lane_sel_t                filters_wr;

	assign access     = psel_i & penable_i;
	assign ctrl_hit   = (paddr_i == apb_map_pkg::CTRL_ADDR);
	assign config_hit = (paddr_i == apb_map_pkg::CONFIG_ADDR);
	assign status_hit = (paddr_i == apb_map_pkg::STATUS_ADDR);
	assign weight_hit = (paddr_i == apb_map_pkg::WEIGHT_ADDR);
	assign neuron_hit = (paddr_i == apb_map_pkg::NEURON_ADDR);

	// addresses below the base wrap to large offsets and miss
	assign result_off  = paddr_i - apb_map_pkg::RESULT_BASE;
	assign result_hit  = (result_off < 4 * conv_pkg::MAX_LANES) && (result_off[1:0] == 2'b00);
	assign result_lane = result_off[3:2];

	assign writable = ctrl_hit | config_hit | weight_hit | neuron_hit;
	assign readable = config_hit | status_hit | result_hit;

	// never stalls
	assign pready_o  = 1'b1;
	assign pslverr_o = access & (pwrite_i ? (~writable | busy_i) : ~readable);
	assign wr_ok     = access & pwrite_i & ~pslverr_o;

	// strobes, start can only pass while idle
	assign start_o       = wr_ok & ctrl_hit & pwdata_i[apb_map_pkg::CTRL_START_BIT];
	assign layer_reset_o = wr_ok & ctrl_hit & pwdata_i[apb_map_pkg::CTRL_LAYER_RESET_BIT];
	assign weight_we_o   = wr_ok & weight_hit;
	assign neuron_we_o   = wr_ok & neuron_hit;
	assign wdata_o       = pwdata_i[conv_pkg::WEIGHT_W-1:0];

	// saturate config fields to what the hardware holds
	always_comb begin
		size_wr    = pwdata_i[apb_map_pkg::CONFIG_SIZE_LSB +: conv_pkg::TAP_W];
		filters_wr = pwdata_i[apb_map_pkg::CONFIG_FILTERS_LSB +: $bits(conv_pkg::lane_sel_t)];
		if (size_wr > POOL_DEPTH - 1) begin
			size_wr = conv_pkg::tap_t'(POOL_DEPTH - 1);
		end
		if (filters_wr > NUM_LANES - 1) begin
			filters_wr = conv_pkg::lane_sel_t'(NUM_LANES - 1);
		end
	end

	// both fields hold value minus one
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			filter_size_o <= '0;
			num_filters_o <= '0;
		end else if (wr_ok && config_hit) begin
			filter_size_o <= size_wr;
			num_filters_o <= filters_wr;
		end
	end

	always_comb begin
		prdata_o = '0;
		if (config_hit) begin
			prdata_o[apb_map_pkg::CONFIG_SIZE_LSB +: conv_pkg::TAP_W] = filter_size_o;
			prdata_o[apb_map_pkg::CONFIG_FILTERS_LSB +: $bits(conv_pkg::lane_sel_t)] =
				num_filters_o;
		end else if (status_hit) begin
			prdata_o[apb_map_pkg::STATUS_BUSY_BIT] = busy_i;
			prdata_o[apb_map_pkg::STATUS_DONE_BIT] = done_i;
		end else if (result_hit && result_lane < NUM_LANES) begin
			// lanes beyond NUM_LANES read as zero
			prdata_o[conv_pkg::ACC_W-1:0] = results_i[result_lane];
		end
	end

endmodule

// ==== rtl/mac_sequencer.sv ====
`timescale 1ns/1ps

module mac_sequencer #(
	parameter int NUM_LANES = 4
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                start_i,
	input  conv_pkg::tap_t      filter_size_i,
	input  conv_pkg::lane_sel_t num_filters_i,
	output logic                busy_o,
	output logic                done_o,
	mac_ctrl_if.seq             ctrl
);

	typedef enum logic [2:0] {
		IDLE,
		CLEAR,
		RUN,
		DRAIN1,
		DRAIN2
	} state_t;

	state_t         state;
	state_t         state_nxt;
	conv_pkg::tap_t iter;
	logic           iter_wrap;

	// iteration pointer, wraps on the last tap
	tap_counter iter_cnt_i (
		.clk     (clk),
		.reset   (reset),
		.clear_i (state == CLEAR),
		.step_i  (state == RUN),
		.limit_i (filter_size_i),
		.count_o (iter),
		.wrap_o  (iter_wrap)
	);

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE:    if (start_i) state_nxt = CLEAR;
			CLEAR:   state_nxt = RUN;
			RUN:     if (iter_wrap) state_nxt = DRAIN1;
			// finish waits for buffer read and MAC stages
			DRAIN1:  state_nxt = DRAIN2;
			DRAIN2:  state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state  <= IDLE;
			done_o <= 1'b0;
		end else begin
			state <= state_nxt;
			if (start_i) begin
				done_o <= 1'b0;
			end else if (state == DRAIN2) begin
				done_o <= 1'b1;
			end
		end
	end

	assign busy_o         = (state != IDLE);
	assign ctrl.tap_valid = (state == RUN);
	assign ctrl.tap_idx   = iter;
	assign ctrl.acc_clear = (state == CLEAR);
	assign ctrl.acc_last  = iter_wrap;

	// enable lanes 0 .. num_filters
	always_comb begin
		for (int k = 0; k < NUM_LANES; k++) begin
			ctrl.lane_mask[k] = (k <= num_filters_i);
		end
	end

endmodule

// ==== rtl/mac_array.sv ====
`timescale 1ns/1ps

module mac_array #(
	parameter int NUM_LANES  = 4,
	parameter int POOL_DEPTH = 36
) (
	input  logic                clk,
	input  logic                reset,
	mac_ctrl_if.array           ctrl,
	input  logic                weight_we_i,
	input  conv_pkg::tap_t      weight_tap_i,
	input  conv_pkg::lane_sel_t weight_lane_i,
	input  conv_pkg::weight_t   wdata_i,
	input  conv_pkg::neuron_t   neuron_i,
	output conv_pkg::acc_t      results_o [NUM_LANES]
);

	logic                 valid_d;
	logic                 clear_d;
	logic                 last_d;
	logic                 last_dd;
	logic [NUM_LANES-1:0] mask_d;

	// control follows the registered buffer read by one cycle
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_d <= 1'b0;
			clear_d <= 1'b0;
			last_d  <= 1'b0;
			last_dd <= 1'b0;
			mask_d  <= '0;
		end else begin
			valid_d <= ctrl.tap_valid;
			clear_d <= ctrl.acc_clear;
			last_d  <= ctrl.acc_last;
			last_dd <= last_d;
			mask_d  <= ctrl.lane_mask;
		end
	end

	for (genvar lane = 0; lane < NUM_LANES; lane++) begin : g_lane
		conv_pkg::weight_t                                weight;
		logic [conv_pkg::WEIGHT_W+conv_pkg::NEURON_W-1:0] product;
		conv_pkg::acc_t                                   acc;
		conv_pkg::acc_t                                   result_q;

		tap_buffer #(
			.payload_t  (conv_pkg::weight_t),
			.POOL_DEPTH (POOL_DEPTH)
		) pool_i (
			.clk     (clk),
			.we_i    (weight_we_i && (weight_lane_i == conv_pkg::lane_sel_t'(lane))),
			.waddr_i (weight_tap_i),
			.wdata_i (wdata_i),
			.raddr_i (ctrl.tap_idx),
			.rdata_o (weight)
		);

		// neuron is shared by every lane
		assign product = weight * neuron_i;

		always_ff @(posedge clk) begin
			if (clear_d) begin
				acc <= '0;
			end else if (valid_d && mask_d[lane]) begin
				acc <= acc + product;
			end
		end

		// acc is final one cycle after the delayed last tap
		always_ff @(posedge clk or posedge reset) begin
			if (reset) begin
				result_q <= '0;
			end else if (last_dd) begin
				result_q <= acc;
			end
		end

		assign results_o[lane] = result_q;
	end

endmodule

// ==== rtl/conv_quad_top.sv ====
`timescale 1ns/1ps

module conv_quad_top #(
	parameter int NUM_LANES  = 4,
	parameter int POOL_DEPTH = 36
) (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               psel_i,
	input  logic                               penable_i,
	input  logic                               pwrite_i,
	input  logic [apb_map_pkg::APB_ADDR_W-1:0] paddr_i,
	input  logic [apb_map_pkg::APB_DATA_W-1:0] pwdata_i,
	output logic [apb_map_pkg::APB_DATA_W-1:0] prdata_o,
	output logic                               pready_o,
	output logic                               pslverr_o
);

	conv_pkg::tap_t      filter_size;
	conv_pkg::lane_sel_t num_filters;
	logic                start;
	logic                layer_reset;
	logic                weight_we;
	logic                neuron_we;
	logic                busy;
	logic                done;
	conv_pkg::weight_t   wdata;
	conv_pkg::tap_t      weight_tap;
	logic                weight_tap_wrap;
	conv_pkg::tap_t      filter_cnt;
	conv_pkg::lane_sel_t weight_lane;
	conv_pkg::tap_t      neuron_ptr;
	conv_pkg::neuron_t   neuron_rd;
	conv_pkg::acc_t      results [NUM_LANES];

	mac_ctrl_if #(.NUM_LANES(NUM_LANES)) mac_if ();

	apb_regs #(
		.NUM_LANES  (NUM_LANES),
		.POOL_DEPTH (POOL_DEPTH)
	) regs_i (
		.clk           (clk),
		.reset         (reset),
		.psel_i        (psel_i),
		.penable_i     (penable_i),
		.pwrite_i      (pwrite_i),
		.paddr_i       (paddr_i),
		.pwdata_i      (pwdata_i),
		.busy_i        (busy),
		.done_i        (done),
		.results_i     (results),
		.prdata_o      (prdata_o),
		.pready_o      (pready_o),
		.pslverr_o     (pslverr_o),
		.filter_size_o (filter_size),
		.num_filters_o (num_filters),
		.start_o       (start),
		.layer_reset_o (layer_reset),
		.weight_we_o   (weight_we),
		.neuron_we_o   (neuron_we),
		.wdata_o       (wdata)
	);

	// weight tap pointer, wrap moves on to the next filter
	tap_counter weight_tap_cnt_i (
		.clk     (clk),
		.reset   (reset),
		.clear_i (layer_reset),
		.step_i  (weight_we),
		.limit_i (filter_size),
		.count_o (weight_tap),
		.wrap_o  (weight_tap_wrap)
	);

	tap_counter filter_sel_cnt_i (
		.clk     (clk),
		.reset   (reset),
		.clear_i (layer_reset),
		.step_i  (weight_tap_wrap),
		.limit_i (conv_pkg::tap_t'(num_filters)),
		.count_o (filter_cnt),
		.wrap_o  ()
	);

	// never exceeds num_filters, so the narrow select is exact
	assign weight_lane = conv_pkg::lane_sel_t'(filter_cnt);

	tap_counter neuron_ptr_cnt_i (
		.clk     (clk),
		.reset   (reset),
		.clear_i (layer_reset),
		.step_i  (neuron_we),
		.limit_i (filter_size),
		.count_o (neuron_ptr),
		.wrap_o  ()
	);

	// neuron window, read in step with the weight pools
	tap_buffer #(
		.payload_t  (conv_pkg::neuron_t),
		.POOL_DEPTH (POOL_DEPTH)
	) neuron_buf_i (
		.clk     (clk),
		.we_i    (neuron_we),
		.waddr_i (neuron_ptr),
		.wdata_i (conv_pkg::neuron_t'(wdata)),
		.raddr_i (mac_if.tap_idx),
		.rdata_o (neuron_rd)
	);

	mac_sequencer #(
		.NUM_LANES (NUM_LANES)
	) seq_i (
		.clk           (clk),
		.reset         (reset),
		.start_i       (start),
		.filter_size_i (filter_size),
		.num_filters_i (num_filters),
		.busy_o        (busy),
		.done_o        (done),
		.ctrl          (mac_if.seq)
	);

	mac_array #(
		.NUM_LANES  (NUM_LANES),
		.POOL_DEPTH (POOL_DEPTH)
	) array_i (
		.clk           (clk),
		.reset         (reset),
		.ctrl          (mac_if.array),
		.weight_we_i   (weight_we),
		.weight_tap_i  (weight_tap),
		.weight_lane_i (weight_lane),
		.wdata_i       (wdata),
		.neuron_i      (neuron_rd),
		.results_o     (results)
	);

endmodule

// ==== sim/conv_quad_tasks.svh ====
`ifndef CONV_QUAD_TASKS_SVH
`define CONV_QUAD_TASKS_SVH

// one APB write: setup phase, then access phase
// pslverr is sampled in the middle of the access phase
task automatic write_reg(
	input  logic [apb_map_pkg::APB_ADDR_W-1:0] addr,
	input  logic [apb_map_pkg::APB_DATA_W-1:0] data,
	output logic                               err
);
	@(posedge clk);
	psel    <= 1'b1;
	penable <= 1'b0;
	pwrite  <= 1'b1;
	paddr   <= addr;
	pwdata  <= data;
	@(posedge clk);
	penable <= 1'b1;
	@(negedge clk);
	err = pslverr;
	@(posedge clk);
	psel    <= 1'b0;
	penable <= 1'b0;
	pwrite  <= 1'b0;
endtask

// one APB read, data and pslverr taken mid access phase
task automatic read_reg(
	input  logic [apb_map_pkg::APB_ADDR_W-1:0] addr,
	output logic [apb_map_pkg::APB_DATA_W-1:0] data,
	output logic                               err
);
	@(posedge clk);
	psel    <= 1'b1;
	penable <= 1'b0;
	pwrite  <= 1'b0;
	paddr   <= addr;
	@(posedge clk);
	penable <= 1'b1;
	@(negedge clk);
	data = prdata;
	err  = pslverr;
	@(posedge clk);
	psel    <= 1'b0;
	penable <= 1'b0;
endtask

// expected dot product of one lane
// lanes at or above the filter count stay zero
function automatic logic [31:0] dot_reference(
	input int lane,
	input int taps,
	input int lanes
);
	logic [31:0] sum;
	sum = '0;
	if (lane < lanes) begin
		for (int t = 0; t < taps; t++) begin
			sum = sum + weights[lane][t] * neurons[t];
		end
	end
	return sum;
endfunction

`endif

// ==== sim/conv_quad_tb.sv ====
`timescale 1ns/1ps

module conv_quad_tb;

	localparam int CLK_PERIOD    = 8;
	localparam int MAX_TAPS      = 36;
	localparam int NUM_PASSES    = 4;
	localparam int ACCESS_CYCLES = 3;
	// weights, neurons, status polls and readback per pass
	localparam int ACCESSES_PER_PASS = 4 * MAX_TAPS + MAX_TAPS + 50;
	localparam int WATCHDOG_CYCLES =
		2 * NUM_PASSES * (MAX_TAPS + 3 + ACCESSES_PER_PASS * ACCESS_CYCLES) + 100;
	localparam int MAX_POLLS = 60;

	logic                               clk;
	logic                               reset;
	logic                               psel;
	logic                               penable;
	logic                               pwrite;
	logic [apb_map_pkg::APB_ADDR_W-1:0] paddr;
	logic [apb_map_pkg::APB_DATA_W-1:0] pwdata;
	logic [apb_map_pkg::APB_DATA_W-1:0] prdata;
	logic                               pready;
	logic                               pslverr;

	integer            seed;
	int                error_count;
	int                check_count;
	conv_pkg::weight_t weights [conv_pkg::MAX_LANES][MAX_TAPS];
	conv_pkg::neuron_t neurons [MAX_TAPS];

	// result readback waiting for the compare process
	int          lane_q [$];
	int          taps_q [$];
	int          lanes_q [$];
	logic [31:0] actual_q [$];

	`include "conv_quad_tasks.svh"

	conv_quad_top #(
		.NUM_LANES  (4),
		.POOL_DEPTH (MAX_TAPS)
	) dut_i (
		.clk       (clk),
		.reset     (reset),
		.psel_i    (psel),
		.penable_i (penable),
		.pwrite_i  (pwrite),
		.paddr_i   (paddr),
		.pwdata_i  (pwdata),
		.prdata_o  (prdata),
		.pready_o  (pready),
		.pslverr_o (pslverr)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic compare_word(
		input string       name,
		input logic [31:0] expected,
		input logic [31:0] actual
	);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("** Error at %0t ns: %s expected 0x%08h, got 0x%08h",
				$time, name, expected, actual);
		end
	endtask

	// poll STATUS until the done bit is set
	task automatic poll_done(output logic [31:0] status);
		logic err;
		int   polls;
		polls  = 0;
		status = '0;
		while (!status[apb_map_pkg::STATUS_DONE_BIT] && polls < MAX_POLLS) begin
			read_reg(apb_map_pkg::STATUS_ADDR, status, err);
			polls++;
		end
		if (!status[apb_map_pkg::STATUS_DONE_BIT]) begin
			error_count++;
			$display("done flag did not rise after %0d status reads", polls);
		end
	endtask

	// random weights in filter-major order, then the neuron window
	task automatic load_window(input int taps, input int lanes);
		logic err;
		for (int l = 0; l < lanes; l++) begin
			for (int t = 0; t < taps; t++) begin
				weights[l][t] = conv_pkg::weight_t'($random(seed));
				write_reg(apb_map_pkg::WEIGHT_ADDR, {24'h0, weights[l][t]}, err);
				compare_word("pslverr_o (weight write)", 32'h0, {31'h0, err});
			end
		end
		for (int t = 0; t < taps; t++) begin
			neurons[t] = conv_pkg::neuron_t'($random(seed));
			write_reg(apb_map_pkg::NEURON_ADDR, {24'h0, neurons[t]}, err);
			compare_word("pslverr_o (neuron write)", 32'h0, {31'h0, err});
		end
	endtask

	// read every RESULT register and hand it to the compare process
	task automatic collect_results(input int taps, input int lanes);
		logic [31:0]                        data;
		logic                               err;
		logic [apb_map_pkg::APB_ADDR_W-1:0] addr;
		for (int k = 0; k < conv_pkg::MAX_LANES; k++) begin
			addr = apb_map_pkg::RESULT_BASE + 4 * k;
			read_reg(addr, data, err);
			compare_word("pslverr_o (result read)", 32'h0, {31'h0, err});
			lane_q.push_back(k);
			taps_q.push_back(taps);
			lanes_q.push_back(lanes);
			actual_q.push_back(data);
		end
		wait (actual_q.size() == 0);
	endtask

	// compare process
	initial begin
		int          lane;
		int          taps;
		int          lanes;
		logic [31:0] actual;
		forever begin
			wait (actual_q.size() != 0);
			lane   = lane_q.pop_front();
			taps   = taps_q.pop_front();
			lanes  = lanes_q.pop_front();
			actual = actual_q.pop_front();
			compare_word($sformatf("prdata_o (result lane %0d)", lane),
				dot_reference(lane, taps, lanes), actual);
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("TB FAILED");
		$finish;
	end

	initial begin
		logic [31:0] data;
		logic        err;
		seed        = 32'h29eb1e01;
		error_count = 0;
		check_count = 0;
		reset       = 1'b1;
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		paddr       = '0;
		pwdata      = '0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;

		// after reset
		read_reg(apb_map_pkg::STATUS_ADDR, data, err);
		compare_word("prdata_o (status)", 32'h0, data);
		compare_word("pslverr_o (status read)", 32'h0, {31'h0, err});
		compare_word("pready_o", 32'h1, {31'h0, pready});
		read_reg(apb_map_pkg::CONFIG_ADDR, data, err);
		compare_word("prdata_o (config)", 32'h0, data);
		compare_word("pslverr_o (config read)", 32'h0, {31'h0, err});
		collect_results(0, 0);

		// full pass with 36 taps and 4 filters
		write_reg(apb_map_pkg::CONFIG_ADDR, 32'h0000_0323, err);
		compare_word("pslverr_o (config write)", 32'h0, {31'h0, err});
		read_reg(apb_map_pkg::CONFIG_ADDR, data, err);
		compare_word("prdata_o (config)", 32'h0000_0323, data);
		load_window(36, 4);
		write_reg(apb_map_pkg::CTRL_ADDR, 32'h1, err);
		compare_word("pslverr_o (start)", 32'h0, {31'h0, err});
		poll_done(data);
		collect_results(36, 4);

		// reduced pass with 9 taps and 2 filters after a layer reset
		write_reg(apb_map_pkg::CONFIG_ADDR, 32'h0000_0108, err);
		compare_word("pslverr_o (config write)", 32'h0, {31'h0, err});
		// move the pointers off zero so the layer reset has work to do
		write_reg(apb_map_pkg::WEIGHT_ADDR, 32'h0000_005a, err);
		write_reg(apb_map_pkg::NEURON_ADDR, 32'h0000_005a, err);
		write_reg(apb_map_pkg::CTRL_ADDR, 32'h2, err);
		compare_word("pslverr_o (layer reset)", 32'h0, {31'h0, err});
		load_window(9, 2);
		write_reg(apb_map_pkg::CTRL_ADDR, 32'h1, err);
		compare_word("pslverr_o (start)", 32'h0, {31'h0, err});
		read_reg(apb_map_pkg::STATUS_ADDR, data, err);
		compare_word("prdata_o (status while busy)", 32'h1, data);
		poll_done(data);
		compare_word("prdata_o (status at done)", 32'h2, data);
		collect_results(9, 2);

		// writes while busy are refused
		write_reg(apb_map_pkg::CTRL_ADDR, 32'h1, err);
		compare_word("pslverr_o (start)", 32'h0, {31'h0, err});
		write_reg(apb_map_pkg::CONFIG_ADDR, 32'h0000_0323, err);
		compare_word("pslverr_o (config write while busy)", 32'h1, {31'h0, err});
		write_reg(apb_map_pkg::WEIGHT_ADDR, 32'h0000_00a5, err);
		compare_word("pslverr_o (weight write while busy)", 32'h1, {31'h0, err});
		poll_done(data);
		read_reg(apb_map_pkg::CONFIG_ADDR, data, err);
		compare_word("prdata_o (config after busy write)", 32'h0000_0108, data);
		collect_results(9, 2);

		// unmapped address and write-only registers
		read_reg(8'h0c, data, err);
		compare_word("pslverr_o (unmapped read)", 32'h1, {31'h0, err});
		read_reg(apb_map_pkg::WEIGHT_ADDR, data, err);
		compare_word("pslverr_o (weight read)", 32'h1, {31'h0, err});
		write_reg(8'h18, 32'h0, err);
		compare_word("pslverr_o (unmapped write)", 32'h1, {31'h0, err});

		// same data again gives the same results
		write_reg(apb_map_pkg::CTRL_ADDR, 32'h1, err);
		poll_done(data);
		collect_results(9, 2);

		$display("%0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+sim
rtl/conv_pkg.sv
rtl/apb_map_pkg.sv
rtl/mac_ctrl_if.sv
rtl/tap_counter.sv
rtl/tap_buffer.sv
rtl/apb_regs.sv
rtl/mac_sequencer.sv
rtl/mac_array.sv
rtl/conv_quad_top.sv
sim/conv_quad_tb.sv
